// File: design/dpa_pkg.sv
// shared widths, frame geometry, header layout and types for the photo frame renderer
package dpa_pkg;

    localparam int addr_w    = 20;
    localparam int data_w    = 24;
    localparam int cr_addr_w = 9;

    // glyph cell, 13 columns by 24 rows
    localparam int glyph_w = 13;
    localparam int glyph_h = 24;

    localparam int frame_dim = 256;

    // the clock text fills the lower right corner
    localparam int clk_x0     = 152;
    localparam int clk_y0     = 232;
    localparam int colon_code = 10;

    localparam int slot_len = 5;

    // header words, photo k descriptor sits at 2k+1 and 2k+2
    localparam int hdr_time  = 0;
    localparam int hdr_frame = 1;
    localparam int hdr_count = 2;

    localparam int size_512_bit = 9;
    localparam int size_256_bit = 8;

    typedef enum logic [1:0] {
        load_hdr,
        load_photo,
        render,
        idle
    } ctrl_state_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

endpackage

// File: design/scan_if.sv
// pixel position and slot phase, driven by the scanner and read by the datapath blocks
interface scan_if;

    logic [7:0] x;
    logic [7:0] y;
    logic [2:0] phase;
    logic       in_clock;
    logic       slot_end;
    logic       last_pixel;

    modport source (output x, y, phase, in_clock, slot_end, last_pixel);

    modport sink (input x, y, phase, in_clock, slot_end, last_pixel);

endinterface

// File: design/dpa_ctrl.sv
// controller FSM, reads the header and photo descriptors, runs frames and takes ticks
module dpa_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sec_tick,
    input  logic [dpa_pkg::data_w-1:0] im_q,
    scan_if.sink                       scan,
    output logic [dpa_pkg::addr_w-1:0] ctrl_a,
    output logic                       ctrl_read,
    output logic                       scan_run,
    output logic                       scan_clear,
    output logic                       time_load,
    output logic                       time_adv,
    output logic [dpa_pkg::addr_w-1:0] frame_start,
    output logic [dpa_pkg::addr_w-1:0] photo_start,
    output logic                       photo_big,
    output logic                       frame_done
);

    dpa_pkg::ctrl_state_t state;

    logic [2:0]                 cnt;
    logic [7:0]                 photo_count;
    logic [7:0]                 photo_idx;
    logic                       issue;
    logic                       rd_valid_q;
    logic [dpa_pkg::addr_w-1:0] rd_addr_q;
    logic [dpa_pkg::addr_w-1:0] photo_base;

    assign photo_base = dpa_pkg::addr_w'({photo_idx, 1'b1});

    assign ctrl_read  = (state != dpa_pkg::render);
    assign scan_run   = (state == dpa_pkg::render);
    assign scan_clear = (state == dpa_pkg::load_hdr) || (state == dpa_pkg::load_photo);
    assign time_load  = rd_valid_q && (rd_addr_q == dpa_pkg::addr_w'(dpa_pkg::hdr_time));

    always_comb begin
        issue  = 1'b0;
        ctrl_a = '0;
        case (state)
            dpa_pkg::load_hdr: begin
                issue  = 1'b1;
                ctrl_a = dpa_pkg::addr_w'(cnt);
            end
            dpa_pkg::load_photo: begin
                issue  = (cnt < 3'd2);
                ctrl_a = photo_base + dpa_pkg::addr_w'(cnt[0]);
            end
            default: begin
                issue = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= dpa_pkg::load_hdr;
            cnt         <= '0;
            photo_idx   <= 8'd1;
            photo_count <= '0;
            rd_valid_q  <= 1'b0;
            rd_addr_q   <= '0;
            time_adv    <= 1'b0;
            frame_done  <= 1'b0;
            frame_start <= '0;
            photo_start <= '0;
            photo_big   <= 1'b0;
        end else begin
            rd_valid_q <= issue;
            rd_addr_q  <= ctrl_a;
            time_adv   <= 1'b0;
            frame_done <= 1'b0;

            // memory data lags the address by a cycle
            if (rd_valid_q) begin
                if (rd_addr_q == dpa_pkg::addr_w'(dpa_pkg::hdr_frame)) begin
                    frame_start <= im_q[dpa_pkg::addr_w-1:0];
                end else if (rd_addr_q == dpa_pkg::addr_w'(dpa_pkg::hdr_count)) begin
                    photo_count <= im_q[7:0];
                end else if (rd_addr_q > dpa_pkg::addr_w'(dpa_pkg::hdr_count)) begin
                    if (rd_addr_q[0]) begin
                        photo_start <= im_q[dpa_pkg::addr_w-1:0];
                    end else begin
                        photo_big <= im_q[dpa_pkg::size_512_bit] & ~im_q[dpa_pkg::size_256_bit];
                    end
                end
            end

            case (state)
                dpa_pkg::load_hdr: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == 3'd4) begin
                        cnt   <= '0;
                        state <= dpa_pkg::render;
                    end
                end
                dpa_pkg::load_photo: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == 3'd2) begin
                        cnt   <= '0;
                        state <= dpa_pkg::render;
                    end
                end
                dpa_pkg::render: begin
                    if (scan.slot_end && scan.last_pixel) begin
                        state      <= dpa_pkg::idle;
                        frame_done <= 1'b1;
                    end
                end
                default: begin
                    if (sec_tick) begin
                        state    <= dpa_pkg::load_photo;
                        time_adv <= 1'b1;
                        // wrap back to photo 1 after the last one
                        photo_idx <= (photo_idx >= photo_count) ? 8'd1 : photo_idx + 8'd1;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/pixel_scan.sv
// raster scanner, steps the slot phase and then the frame position, flags the clock region
module pixel_scan (
    input  logic  clk,
    input  logic  reset,
    input  logic  scan_run,
    input  logic  scan_clear,
    scan_if.source scan
);

    logic phase_last;

    assign phase_last = (scan.phase == 3'(dpa_pkg::slot_len - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan.x     <= '0;
            scan.y     <= '0;
            scan.phase <= '0;
        end else if (scan_clear) begin
            scan.x     <= '0;
            scan.y     <= '0;
            scan.phase <= '0;
        end else if (scan_run) begin
            if (phase_last) begin
                scan.phase <= '0;
                scan.x     <= scan.x + 8'd1;
                // x wraps on its own at the row end
                if (scan.x == 8'(dpa_pkg::frame_dim - 1)) begin
                    scan.y <= scan.y + 8'd1;
                end
            end else begin
                scan.phase <= scan.phase + 3'd1;
            end
        end
    end

    assign scan.slot_end = phase_last;

    assign scan.in_clock = (scan.x >= 8'(dpa_pkg::clk_x0)) &&
                           (scan.y >= 8'(dpa_pkg::clk_y0));

    assign scan.last_pixel = (scan.x == 8'(dpa_pkg::frame_dim - 1)) &&
                             (scan.y == 8'(dpa_pkg::frame_dim - 1));

endmodule

// File: design/addr_gen.sv
// image memory address and write enable for each slot phase
module addr_gen (
    scan_if.sink                       scan,
    input  logic [dpa_pkg::addr_w-1:0] photo_start,
    input  logic [dpa_pkg::addr_w-1:0] frame_start,
    input  logic                       photo_big,
    input  logic [dpa_pkg::addr_w-1:0] ctrl_a,
    input  logic                       ctrl_read,
    output logic [dpa_pkg::addr_w-1:0] im_a,
    output logic                       im_wen
);

    logic [17:0] big_off;
    logic [15:0] pix_off;

    // (2y+dy)*512 + 2x+dx, phase bit 1 picks the row and bit 0 the column
    assign big_off = {scan.y, scan.phase[1], scan.x, scan.phase[0]};
    assign pix_off = {scan.y, scan.x};

    always_comb begin
        im_wen = 1'b1;
        if (ctrl_read) begin
            im_a = ctrl_a;
        end else if (scan.slot_end) begin
            im_a   = frame_start + dpa_pkg::addr_w'(pix_off);
            im_wen = 1'b0;
        end else if (photo_big) begin
            im_a = photo_start + dpa_pkg::addr_w'(big_off);
        end else begin
            // small photo reads the same word every phase, only phase 0 counts
            im_a = photo_start + dpa_pkg::addr_w'(pix_off);
        end
    end

endmodule

// File: design/pixel_avg.sv
// channel sums over a slot, gives the 2x2 floor average or the copied source word
module pixel_avg (
    input  logic                       clk,
    input  logic                       reset,
    scan_if.sink                       scan,
    input  logic                       photo_big,
    input  logic [dpa_pkg::data_w-1:0] im_q,
    output dpa_pkg::pixel_t            src_pixel
);

    logic [2:0][9:0]              sum;
    logic [2:0][9:0]              total;
    logic [dpa_pkg::data_w-1:0]   avg_word;
    logic [dpa_pkg::data_w-1:0]   copy_word;

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            total[c]           = sum[c] + 10'(im_q[8*c +: 8]);
            avg_word[8*c +: 8]  = total[c][9:2];
            copy_word[8*c +: 8] = sum[c][7:0];
        end
    end

    // word from phase k arrives in phase k+1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum <= '0;
        end else if (scan.phase == 3'd0) begin
            sum <= '0;
        end else if (!scan.slot_end && (photo_big || scan.phase == 3'd1)) begin
            sum <= total;
        end
    end

    assign src_pixel = dpa_pkg::pixel_t'(photo_big ? avg_word : copy_word);

endmodule

// File: design/time_keeper.sv
// hh:mm:ss counters loaded from the header and stepped once per tick, with decimal digits
module time_keeper (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       time_load,
    input  logic                       time_adv,
    input  logic [dpa_pkg::data_w-1:0] im_q,
    output logic [7:0][3:0]            digits
);

    logic [4:0] hours;
    logic [5:0] minutes;
    logic [5:0] seconds;
    logic [7:0] hour_bcd;
    logic [7:0] min_bcd;
    logic [7:0] sec_bcd;

    function automatic logic [7:0] split_bcd(input logic [5:0] v);
        logic [3:0] tens;
        logic [3:0] units;
        tens  = 4'(v / 6'd10);
        units = 4'(v % 6'd10);
        return {tens, units};
    endfunction

    assign hour_bcd = split_bcd(6'(hours));
    assign min_bcd  = split_bcd(minutes);
    assign sec_bcd  = split_bcd(seconds);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hours   <= '0;
            minutes <= '0;
            seconds <= '0;
        end else if (time_load) begin
            hours   <= im_q[20:16];
            minutes <= im_q[13:8];
            seconds <= im_q[5:0];
        end else if (time_adv) begin
            if (seconds == 6'd59) begin
                seconds <= '0;
                if (minutes == 6'd59) begin
                    minutes <= '0;
                    hours   <= (hours == 5'd23) ? 5'd0 : hours + 5'd1;
                end else begin
                    minutes <= minutes + 6'd1;
                end
            end else begin
                seconds <= seconds + 6'd1;
            end
        end
    end

    // left to right as drawn
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            digits <= '0;
        end else begin
            digits[0] <= hour_bcd[7:4];
            digits[1] <= hour_bcd[3:0];
            digits[2] <= 4'(dpa_pkg::colon_code);
            digits[3] <= min_bcd[7:4];
            digits[4] <= min_bcd[3:0];
            digits[5] <= 4'(dpa_pkg::colon_code);
            digits[6] <= sec_bcd[7:4];
            digits[7] <= sec_bcd[3:0];
        end
    end

endmodule

// File: design/glyph_render.sv
// character ROM lookup for the clock text and final pixel select for the frame write
module glyph_render (
    input  logic                          clk,
    input  logic                          reset,
    scan_if.sink                          scan,
    input  logic [7:0][3:0]               digits,
    input  logic [dpa_pkg::glyph_w-1:0]   cr_q,
    input  dpa_pkg::pixel_t               src_pixel,
    output logic [dpa_pkg::cr_addr_w-1:0] cr_a,
    output logic [dpa_pkg::data_w-1:0]    im_d
);

    logic [7:0] rel_x;
    logic [2:0] char_idx;
    logic [3:0] col;
    logic [4:0] row;
    logic [3:0] col_q;
    logic       pix_on;

    assign rel_x    = scan.x - 8'(dpa_pkg::clk_x0);
    assign char_idx = 3'(rel_x / 8'(dpa_pkg::glyph_w));
    assign col      = 4'(rel_x % 8'(dpa_pkg::glyph_w));
    assign row      = 5'(scan.y - 8'(dpa_pkg::clk_y0));

    // registered at the end of phase 2 so the ROM sees it in phase 3
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cr_a  <= '0;
            col_q <= '0;
        end else if (scan.in_clock && scan.phase == 3'd2) begin
            cr_a  <= dpa_pkg::cr_addr_w'(dpa_pkg::glyph_h * digits[char_idx] + row);
            col_q <= col;
        end
    end

    // leftmost column is the msb of the glyph row
    assign pix_on = cr_q[4'(dpa_pkg::glyph_w - 1) - col_q];

    assign im_d = scan.in_clock ? {dpa_pkg::data_w{pix_on}} : src_pixel;

endmodule

// File: design/dpa_top.sv
// top level of the photo frame renderer, memory and ROM ports go to the testbench models
module dpa_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          sec_tick,
    output logic [dpa_pkg::addr_w-1:0]    im_a,
    input  logic [dpa_pkg::data_w-1:0]    im_q,
    output logic [dpa_pkg::data_w-1:0]    im_d,
    output logic                          im_wen,
    output logic [dpa_pkg::cr_addr_w-1:0] cr_a,
    input  logic [dpa_pkg::glyph_w-1:0]   cr_q,
    output logic                          frame_done
);

    logic [dpa_pkg::addr_w-1:0] ctrl_a;
    logic                       ctrl_read;
    logic                       scan_run;
    logic                       scan_clear;
    logic                       time_load;
    logic                       time_adv;
    logic [dpa_pkg::addr_w-1:0] frame_start;
    logic [dpa_pkg::addr_w-1:0] photo_start;
    logic                       photo_big;
    logic [7:0][3:0]            digits;
    dpa_pkg::pixel_t            src_pixel;

    scan_if scan ();

    dpa_ctrl dpa_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .sec_tick    (sec_tick),
        .im_q        (im_q),
        .scan        (scan.sink),
        .ctrl_a      (ctrl_a),
        .ctrl_read   (ctrl_read),
        .scan_run    (scan_run),
        .scan_clear  (scan_clear),
        .time_load   (time_load),
        .time_adv    (time_adv),
        .frame_start (frame_start),
        .photo_start (photo_start),
        .photo_big   (photo_big),
        .frame_done  (frame_done)
    );

    pixel_scan pixel_scan_i (
        .clk        (clk),
        .reset      (reset),
        .scan_run   (scan_run),
        .scan_clear (scan_clear),
        .scan       (scan.source)
    );

    addr_gen addr_gen_i (
        .scan        (scan.sink),
        .photo_start (photo_start),
        .frame_start (frame_start),
        .photo_big   (photo_big),
        .ctrl_a      (ctrl_a),
        .ctrl_read   (ctrl_read),
        .im_a        (im_a),
        .im_wen      (im_wen)
    );

    pixel_avg pixel_avg_i (
        .clk       (clk),
        .reset     (reset),
        .scan      (scan.sink),
        .photo_big (photo_big),
        .im_q      (im_q),
        .src_pixel (src_pixel)
    );

    time_keeper time_keeper_i (
        .clk       (clk),
        .reset     (reset),
        .time_load (time_load),
        .time_adv  (time_adv),
        .im_q      (im_q),
        .digits    (digits)
    );

    glyph_render glyph_render_i (
        .clk       (clk),
        .reset     (reset),
        .scan      (scan.sink),
        .digits    (digits),
        .cr_q      (cr_q),
        .src_pixel (src_pixel),
        .cr_a      (cr_a),
        .im_d      (im_d)
    );

endmodule

// File: bench/dpa_chk.sv
// protocol assertions on the renderer ports, bound into the top level of the design
module dpa_chk (
    input logic                          clk,
    input logic                          reset,
    input logic                          im_wen,
    input logic                          frame_done,
    input logic [dpa_pkg::cr_addr_w-1:0] cr_a
);

    localparam int rom_rows = 11 * dpa_pkg::glyph_h;

    // one write per slot, so never two in a row
    wen_single: assert property (
        @(posedge clk) disable iff (reset) !im_wen |=> im_wen
    ) else $error("im_wen low on two consecutive cycles");

    done_pulse: assert property (
        @(posedge clk) disable iff (reset) frame_done |=> !frame_done
    ) else $error("frame_done high for more than one cycle");

    cr_range: assert property (
        @(posedge clk) disable iff (reset) cr_a < dpa_pkg::cr_addr_w'(rom_rows)
    ) else $error("cr_a points past the last glyph row");

endmodule

bind dpa_top dpa_chk dpa_chk_i (
    .clk        (clk),
    .reset      (reset),
    .im_wen     (im_wen),
    .frame_done (frame_done),
    .cr_a       (cr_a)
);

// File: bench/dpa_tb.sv
// testbench for the photo frame renderer that runs a random album through several ticks
module dpa_tb;

    localparam int mem_words     = 1 << dpa_pkg::addr_w;
    localparam int rom_rows      = 11 * dpa_pkg::glyph_h;
    localparam int frame_words   = dpa_pkg::frame_dim * dpa_pkg::frame_dim;
    localparam int frame_timeout = frame_words * dpa_pkg::slot_len + 1000;
    localparam int n_ticks       = 4;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          sec_tick;
    logic [dpa_pkg::addr_w-1:0]    im_a;
    logic [dpa_pkg::data_w-1:0]    im_q = '0;
    logic [dpa_pkg::data_w-1:0]    im_d;
    logic                          im_wen;
    logic [dpa_pkg::cr_addr_w-1:0] cr_a;
    logic [dpa_pkg::glyph_w-1:0]   cr_q = '0;
    logic                          frame_done;

    logic [dpa_pkg::data_w-1:0]  mem [mem_words];
    logic [dpa_pkg::glyph_w-1:0] rom [rom_rows];

    // album as written into memory plus the expected clock and photo
    int unsigned p_start [$];
    logic        p_big   [$];
    int unsigned frame_base;
    int          n_photos;
    int          cur_photo = 1;
    int          t_hh;
    int          t_mm;
    int          t_ss;
    int          errors = 0;
    int          timeouts = 0;
    int          frames_done = 0;
    int          write_cnt = 0;

    dpa_top dpa_top_i (
        .clk        (clk),
        .reset      (reset),
        .sec_tick   (sec_tick),
        .im_a       (im_a),
        .im_q       (im_q),
        .im_d       (im_d),
        .im_wen     (im_wen),
        .cr_a       (cr_a),
        .cr_q       (cr_q),
        .frame_done (frame_done)
    );

    always #5 clk = ~clk;

    // image memory and character ROM with one cycle read latency
    always @(posedge clk) begin
        if (im_wen == 1'b0) begin
            mem[im_a] <= im_d;
        end
        im_q <= mem[im_a];
        cr_q <= (int'(cr_a) < rom_rows) ? rom[cr_a] : '0;
    end

    task automatic build_album;
        int          a;
        int          k;
        int unsigned cursor;
        for (a = 0; a < mem_words; a++) begin
            mem[dpa_pkg::addr_w'(a)] = dpa_pkg::data_w'($urandom);
        end
        for (a = 0; a < rom_rows; a++) begin
            rom[dpa_pkg::cr_addr_w'(a)] = dpa_pkg::glyph_w'($urandom);
        end
        n_photos = 2 + int'($urandom % 2);
        cursor   = 16 + $urandom % 256;
        for (k = 0; k < n_photos; k++) begin
            // second photo takes the other size so both paths get rendered
            p_big.push_back((k == 1) ? !p_big[0] : (($urandom % 2) == 1));
            p_start.push_back(cursor);
            cursor = cursor + (p_big[k] ? 512 * 512 : 256 * 256) + $urandom % 256;
        end
        frame_base = cursor;
        // close to midnight so a few ticks roll every field over
        t_hh = 23;
        t_mm = 59;
        t_ss = 56 + int'($urandom % 3);
        mem[0] = dpa_pkg::data_w'((t_hh << 16) | (t_mm << 8) | t_ss);
        mem[1] = dpa_pkg::data_w'(frame_base);
        mem[2] = dpa_pkg::data_w'(n_photos);
        for (k = 0; k < n_photos; k++) begin
            mem[dpa_pkg::addr_w'(2 * k + 3)] = dpa_pkg::data_w'(p_start[k]);
            mem[dpa_pkg::addr_w'(2 * k + 4)] = p_big[k] ? 24'h000200 : 24'h000100;
        end
    endtask

    task automatic advance_time;
        if (t_ss < 59) begin
            t_ss = t_ss + 1;
        end else begin
            t_ss = 0;
            if (t_mm < 59) begin
                t_mm = t_mm + 1;
            end else begin
                t_mm = 0;
                t_hh = (t_hh + 1) % 24;
            end
        end
    endtask

    function automatic int digit_code(input int idx);
        case (idx)
            0: return t_hh / 10;
            1: return t_hh % 10;
            3: return t_mm / 10;
            4: return t_mm % 10;
            6: return t_ss / 10;
            7: return t_ss % 10;
            default: return dpa_pkg::colon_code;
        endcase
    endfunction

    function automatic logic [7:0] avg4(input logic [7:0] a, input logic [7:0] b,
                                        input logic [7:0] c, input logic [7:0] d);
        int s;
        s = int'(a) + int'(b) + int'(c) + int'(d);
        return 8'(s / 4);
    endfunction

    function automatic logic [dpa_pkg::data_w-1:0] expected_word(input int x, input int y);
        int                          rel;
        int                          rom_idx;
        int                          base;
        logic [dpa_pkg::glyph_w-1:0] row_bits;
        logic [3:0]                  bit_idx;
        logic [dpa_pkg::data_w-1:0]  m0;
        logic [dpa_pkg::data_w-1:0]  m1;
        logic [dpa_pkg::data_w-1:0]  m2;
        logic [dpa_pkg::data_w-1:0]  m3;
        if (x >= dpa_pkg::clk_x0 && y >= dpa_pkg::clk_y0) begin
            rel      = x - dpa_pkg::clk_x0;
            rom_idx  = digit_code(rel / dpa_pkg::glyph_w) * dpa_pkg::glyph_h + y - dpa_pkg::clk_y0;
            row_bits = rom[dpa_pkg::cr_addr_w'(rom_idx)];
            // leftmost column is the top bit of the row
            bit_idx  = 4'(dpa_pkg::glyph_w - 1 - rel % dpa_pkg::glyph_w);
            return row_bits[bit_idx] ? '1 : '0;
        end
        base = int'(p_start[cur_photo - 1]);
        if (!p_big[cur_photo - 1]) begin
            return mem[dpa_pkg::addr_w'(base + y * dpa_pkg::frame_dim + x)];
        end
        base = base + 2 * y * 512 + 2 * x;
        m0   = mem[dpa_pkg::addr_w'(base)];
        m1   = mem[dpa_pkg::addr_w'(base + 1)];
        m2   = mem[dpa_pkg::addr_w'(base + 512)];
        m3   = mem[dpa_pkg::addr_w'(base + 513)];
        return {avg4(m0[23:16], m1[23:16], m2[23:16], m3[23:16]),
                avg4(m0[15:8], m1[15:8], m2[15:8], m3[15:8]),
                avg4(m0[7:0], m1[7:0], m2[7:0], m3[7:0])};
    endfunction

    task automatic report_mismatch(input string name, input int x, input int y,
                                   input logic [31:0] exp_val, input logic [31:0] act_val);
        errors++;
        $display("MISMATCH %s frame %0d x %0d y %0d expected %h actual %h",
                 name, frames_done, x, y, exp_val, act_val);
    endtask

    task automatic check_write;
        int                         x;
        int                         y;
        logic [dpa_pkg::data_w-1:0] exp_word;
        string                      name;
        x        = write_cnt % dpa_pkg::frame_dim;
        y        = write_cnt / dpa_pkg::frame_dim;
        exp_word = expected_word(x, y);
        if (im_a !== dpa_pkg::addr_w'(frame_base + write_cnt)) begin
            report_mismatch("frame_address", x, y, 32'(frame_base + write_cnt), 32'(im_a));
        end
        if (x >= dpa_pkg::clk_x0 && y >= dpa_pkg::clk_y0) begin
            name = "clock_overlay";
        end else if (p_big[cur_photo - 1]) begin
            name = "average_2x2";
        end else begin
            name = "copy_256";
        end
        if (im_d !== exp_word) begin
            report_mismatch(name, x, y, 32'(exp_word), 32'(im_d));
        end
    endtask

    // frame writes arrive in raster order at one per slot
    always @(posedge clk) begin
        if (reset) begin
            if (im_wen !== 1'b1 || frame_done !== 1'b0) begin
                errors++;
                $display("im_wen or frame_done active while reset is held");
            end
        end else begin
            if (im_wen === 1'b0) begin
                check_write();
                write_cnt++;
            end
            if (frame_done === 1'b1) begin
                if (write_cnt != frame_words) begin
                    errors++;
                    $display("MISMATCH frame_write_count frame %0d expected %0d actual %0d",
                             frames_done, frame_words, write_cnt);
                end
                write_cnt = 0;
                frames_done++;
            end
        end
    end

    task automatic wait_frame_done;
        int n;
        n = 0;
        @(posedge clk);
        while (frame_done !== 1'b1 && n < frame_timeout) begin
            @(posedge clk);
            n++;
        end
        if (frame_done !== 1'b1) begin
            timeouts++;
            $display("timeout while waiting for frame_done");
        end
    endtask

    initial begin
        int t;
        int gap;
        void'($urandom(14));
        reset    = 1'b1;
        sec_tick = 1'b0;
        build_album();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        wait_frame_done();
        for (t = 0; t < n_ticks && timeouts == 0; t++) begin
            gap = 1 + int'($urandom % 4);
            repeat (gap) @(posedge clk);
            sec_tick <= 1'b1;
            advance_time();
            cur_photo = (cur_photo >= n_photos) ? 1 : cur_photo + 1;
            @(posedge clk);
            sec_tick <= 1'b0;
            // stray tick while the frame renders is to be dropped
            gap = 100 + int'($urandom % 400);
            repeat (gap) @(posedge clk);
            sec_tick <= 1'b1;
            @(posedge clk);
            sec_tick <= 1'b0;
            wait_frame_done();
        end
        $display("run complete: %0d frames, %0d errors, %0d timeouts",
                 frames_done, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
design/dpa_pkg.sv
design/scan_if.sv
design/dpa_ctrl.sv
design/pixel_scan.sv
design/addr_gen.sv
design/pixel_avg.sv
design/time_keeper.sv
design/glyph_render.sv
design/dpa_top.sv
bench/dpa_chk.sv
bench/dpa_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = dpa_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
